// File: filelist.f
+incdir+test
hw/huffman_pkg.sv
hw/symbol_counter.sv
hw/leaf_sorter.sv
hw/merge_engine.sv
hw/code_builder.sv
hw/huffman_ctrl.sv
hw/huffman_top.sv
test/tb_huffman.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the huffman encoder testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_huffman -o sim_huffman
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_huffman 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
else
	echo "pass message not found"
	exit 1
fi

// File: test/huffman_model.svh
`ifndef HUFFMAN_MODEL_SVH
`define HUFFMAN_MODEL_SVH

// ========================================
// random numbers
// ========================================
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// ========================================
// reference huffman model
// ========================================
// counts: 6 x 8 bits, symbol k at byte k-1
// result: 6 x {code, mask}, symbol k at slot k-1
function automatic logic [95:0] ref_codes(input logic [47:0] cnts);
	int          ncnt [6];
	logic [5:0]  nmem [6];
	logic [5:0]  lo [5];
	logic [5:0]  hi [5];
	logic [7:0]  code;
	logic [7:0]  mask;
	logic [95:0] res;
	logic [5:0]  m;
	int          n;
	int          pos;
	int          c;
	n = 0;
	// leaves in symbol order, a tie leaves the later symbol in front
	for (int s = 0; s < 6; s++) begin
		c = int'(cnts[8*s +: 8]);
		pos = 0;
		while (pos < n && ncnt[pos] < c)
			pos++;
		for (int i = n; i > pos; i--) begin
			ncnt[i] = ncnt[i-1];
			nmem[i] = nmem[i-1];
		end
		ncnt[pos] = c;
		nmem[pos] = 6'(1 << s);
		n++;
	end
	// merge the front pair, reinsert ahead of counts >= the sum
	for (int k = 0; k < 5; k++) begin
		lo[k] = nmem[0];
		hi[k] = nmem[1];
		c = ncnt[0] + ncnt[1];
		m = nmem[0] | nmem[1];
		for (int i = 0; i < n - 2; i++) begin
			ncnt[i] = ncnt[i+2];
			nmem[i] = nmem[i+2];
		end
		n = n - 2;
		pos = 0;
		while (pos < n && ncnt[pos] < c)
			pos++;
		for (int i = n; i > pos; i--) begin
			ncnt[i] = ncnt[i-1];
			nmem[i] = nmem[i-1];
		end
		ncnt[pos] = c;
		nmem[pos] = m;
		n++;
	end
	// root first, high side 0 and low side 1
	res = '0;
	for (int s = 0; s < 6; s++) begin
		code = '0;
		mask = '0;
		for (int k = 4; k >= 0; k--) begin
			if (hi[k][s]) begin
				code = code << 1;
				mask = (mask << 1) | 8'd1;
			end else if (lo[k][s]) begin
				code = (code << 1) | 8'd1;
				mask = (mask << 1) | 8'd1;
			end
		end
		res[16*s +: 16] = {code, mask};
	end
	return res;
endfunction

`endif

// File: test/tb_huffman.sv
`default_nettype none

module tb_huffman;

	localparam logic [31:0] SEED = 32'he7c2_6b53;
	// 11 frames, 300 cycles each at most
	localparam int MAX_CYCLES = 11 * 300;

	logic        clk;
	logic        reset;
	logic        gray_valid;
	logic [7:0]  gray_data;
	logic        cnt_valid;
	logic [47:0] counts;
	logic        code_valid;
	logic [95:0] codes;

	logic [47:0] exp_counts;
	logic [95:0] exp_codes;
	logic [31:0] rng;
	logic [7:0]  samples [$];
	logic        seen_cnt;
	logic        seen_code;
	int          cycles;
	int          len;

	`include "huffman_model.svh"

	huffman_top dut (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.counts     (counts),
		.code_valid (code_valid),
		.codes      (codes)
	);

	always #4 clk = ~clk;

	// ========================================
	// error reporting and timeout
	// ========================================
	task automatic report_mismatch(input string name, input logic [95:0] expected,
		input logic [95:0] actual);
		$display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("** Error at time %0t: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "%s", what);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			report_failure("timeout, no code_valid within the cycle budget");
	end

	// ========================================
	// code set properties
	// ========================================
	function automatic bit prefix_free(input logic [95:0] cw);
		int         li;
		int         lj;
		logic [7:0] ci;
		logic [7:0] cj;
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 6; j++) begin
				ci = cw[16*i+8 +: 8];
				cj = cw[16*j+8 +: 8];
				li = $countones(cw[16*i +: 8]);
				lj = $countones(cw[16*j +: 8]);
				if (i != j && li <= lj && (cj >> (lj - li)) == ci)
					return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// sum of 2^(8 - length), a full tree gives 256
	function automatic int kraft_sum(input logic [95:0] cw);
		int sum;
		sum = 0;
		for (int i = 0; i < 6; i++)
			sum += 1 << (8 - $countones(cw[16*i +: 8]));
		return sum;
	endfunction

	// frame bookkeeping for the pulse checks
	always @(posedge clk) begin
		if (reset) begin
			seen_cnt  <= 1'b0;
			seen_code <= 1'b0;
		end else begin
			if (cnt_valid)
				seen_cnt <= 1'b1;
			if (code_valid)
				seen_code <= 1'b1;
		end
	end

	a_quiet_reset: assert property (@(posedge clk) $past(reset) |-> !cnt_valid && !code_valid)
		else report_failure("valid output high during or right after reset");
	a_cnt_pulse: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |-> !seen_cnt ##1 !cnt_valid)
		else report_failure("cnt_valid is not a single pulse per frame");
	a_code_pulse: assert property (@(posedge clk) disable iff (reset)
		code_valid |-> seen_cnt && !seen_code ##1 !code_valid)
		else report_failure("code_valid not a single pulse after cnt_valid");
	a_counts: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |-> counts == exp_counts)
		else report_mismatch("counts", 96'(exp_counts), 96'(counts));
	a_codes: assert property (@(posedge clk) disable iff (reset)
		code_valid |-> codes == exp_codes)
		else report_mismatch("codes", exp_codes, codes);
	a_prefix: assert property (@(posedge clk) disable iff (reset)
		code_valid |-> prefix_free(codes))
		else report_failure("codes are not prefix-free");
	a_kraft: assert property (@(posedge clk) disable iff (reset)
		code_valid |-> kraft_sum(codes) == 256)
		else report_mismatch("kraft sum of codes", 96'(256), 96'(kraft_sum(codes)));
	a_hold: assert property (@(posedge clk) disable iff (reset)
		seen_code |-> $stable(codes) && $stable(counts) && !cnt_valid && !code_valid)
		else report_failure("outputs moved or a valid pulsed after code_valid");

	// ========================================
	// stimulus
	// ========================================
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic add_run(input int sym, input int n);
		for (int i = 0; i < n; i++)
			samples.push_back(8'(sym));
	endtask

	task automatic run_frame();
		int sym;
		reset = 1'b1;
		gray_valid = 1'b0;
		repeat (8) step();
		reset = 1'b0;
		exp_counts = '0;
		foreach (samples[i]) begin
			gray_valid = 1'b1;
			gray_data = samples[i];
			sym = int'(samples[i]);
			if (sym >= 1 && sym <= 6)
				exp_counts[8*(sym-1) +: 8] = exp_counts[8*(sym-1) +: 8] + 8'd1;
			step();
		end
		gray_valid = 1'b0;
		gray_data = 8'd0;
		exp_codes = ref_codes(exp_counts);
		while (code_valid !== 1'b1)
			step();
		// a second stream after the report must change nothing
		gray_valid = 1'b1;
		gray_data = 8'd2;
		repeat (4) step();
		gray_valid = 1'b0;
		repeat (4) step();
		samples.delete();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = 8'd0;
		cycles = 0;
		rng = SEED;
		// all counts equal
		for (int r = 0; r < 10; r++)
			for (int s = 1; s <= 6; s++)
				samples.push_back(8'(s));
		run_frame();
		// symbols 2 and 5 never sent
		add_run(1, 5);
		add_run(3, 5);
		add_run(4, 2);
		add_run(6, 1);
		run_frame();
		// skewed
		add_run(1, 100);
		add_run(2, 40);
		add_run(3, 20);
		add_run(4, 8);
		add_run(5, 3);
		add_run(6, 1);
		run_frame();
		for (int f = 0; f < 8; f++) begin
			rng = xorshift(rng);
			len = 1 + int'(rng % 200);
			for (int i = 0; i < len; i++) begin
				rng = xorshift(rng);
				// odd frames carry stray values
				if (f % 2 == 1 && rng[4:2] == 3'd0)
					samples.push_back(rng[6:5] == 2'd0 ? 8'd0 : rng[6:5] == 2'd1 ? 8'd7 : 8'd255);
				else
					samples.push_back(8'(1 + rng[15:8] % 6));
			end
			run_frame();
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/huffman_top.sv
`default_nettype none

module huffman_top (
	input  wire                                            clk,
	input  wire                                            reset,
	input  wire                                            gray_valid,
	input  wire  [7:0]                                     gray_data,
	output logic                                           cnt_valid,
	output huffman_pkg::count_t [huffman_pkg::NUM_SYM-1:0] counts,
	output logic                                           code_valid,
	output huffman_pkg::code_t [huffman_pkg::NUM_SYM-1:0]  codes
);

	logic sort_start;
	logic merge_start;
	logic split_start;
	logic sort_done;
	logic merge_done;
	logic split_done;
	huffman_pkg::node_t [huffman_pkg::NUM_SYM-1:0]        sorted;
	huffman_pkg::merge_rec_t [huffman_pkg::NUM_MERGE-1:0] records;

	huffman_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.gray_valid  (gray_valid),
		.sort_done   (sort_done),
		.merge_done  (merge_done),
		.split_done  (split_done),
		.sort_start  (sort_start),
		.merge_start (merge_start),
		.split_start (split_start),
		.cnt_valid   (cnt_valid),
		.code_valid  (code_valid)
	);

	symbol_counter u_counter (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.counts     (counts)
	);

	leaf_sorter u_sorter (
		.clk    (clk),
		.reset  (reset),
		.start  (sort_start),
		.counts (counts),
		.sorted (sorted),
		.done   (sort_done)
	);

	merge_engine u_merge (
		.clk     (clk),
		.reset   (reset),
		.start   (merge_start),
		.sorted  (sorted),
		.records (records),
		.done    (merge_done)
	);

	code_builder u_builder (
		.clk     (clk),
		.reset   (reset),
		.start   (split_start),
		.records (records),
		.codes   (codes),
		.done    (split_done)
	);

endmodule

`default_nettype wire

// File: hw/huffman_ctrl.sv
`default_nettype none

module huffman_ctrl (
	input  wire  clk,
	input  wire  reset,
	input  wire  gray_valid,
	input  wire  sort_done,
	input  wire  merge_done,
	input  wire  split_done,
	output logic sort_start,
	output logic merge_start,
	output logic split_start,
	output logic cnt_valid,
	output logic code_valid
);

	huffman_pkg::phase_e state;
	huffman_pkg::phase_e state_next;

	// ========================================
	// phase FSM
	// ========================================
	always_comb begin
		state_next = state;
		case (state)
			huffman_pkg::IDLE:
				if (gray_valid)
					state_next = huffman_pkg::RECEIVE;
			huffman_pkg::RECEIVE:
				if (!gray_valid)
					state_next = huffman_pkg::COUNT_OUT;
			huffman_pkg::COUNT_OUT:
				state_next = huffman_pkg::SORT;
			huffman_pkg::SORT:
				if (sort_done)
					state_next = huffman_pkg::MERGE;
			huffman_pkg::MERGE:
				if (merge_done)
					state_next = huffman_pkg::SPLIT;
			huffman_pkg::SPLIT:
				if (split_done)
					state_next = huffman_pkg::CODE_OUT;
			huffman_pkg::CODE_OUT:
				state_next = huffman_pkg::DONE;
			// held here until reset
			huffman_pkg::DONE:
				state_next = huffman_pkg::DONE;
			default:
				state_next = huffman_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= huffman_pkg::IDLE;
		else
			state <= state_next;
	end

	// start pulses land in the first cycle of each unit's phase
	always_ff @(posedge clk) begin
		if (reset) begin
			sort_start  <= 1'b0;
			merge_start <= 1'b0;
			split_start <= 1'b0;
		end else begin
			sort_start  <= (state == huffman_pkg::COUNT_OUT);
			merge_start <= (state == huffman_pkg::SORT) && sort_done;
			split_start <= (state == huffman_pkg::MERGE) && merge_done;
		end
	end

	assign cnt_valid  = (state == huffman_pkg::COUNT_OUT);
	assign code_valid = (state == huffman_pkg::CODE_OUT);

	a_valid_excl: assert property (@(posedge clk) disable iff (reset)
		!(cnt_valid && code_valid))
		else $error("cnt_valid and code_valid high together");

endmodule

`default_nettype wire

// File: hw/code_builder.sv
`default_nettype none

module code_builder (
	input  wire                                                      clk,
	input  wire                                                      reset,
	input  wire                                                      start,
	input  wire  huffman_pkg::merge_rec_t [huffman_pkg::NUM_MERGE-1:0] records,
	output huffman_pkg::code_t [huffman_pkg::NUM_SYM-1:0]            codes,
	output logic                                                     done
);

	localparam int W = huffman_pkg::CODE_W;

	logic       busy;
	logic [2:0] idx;
	logic [2:0] idx_now;
	huffman_pkg::merge_rec_t rec;
	huffman_pkg::code_t [huffman_pkg::NUM_SYM-1:0] base;
	huffman_pkg::code_t [huffman_pkg::NUM_SYM-1:0] next_codes;

	// ========================================
	// one record per cycle, root first
	// ========================================
	always_comb begin
		idx_now    = start ? 3'(huffman_pkg::NUM_MERGE - 1) : idx;
		rec        = records[idx_now];
		base       = start ? '0 : codes;
		next_codes = base;
		for (int k = 0; k < huffman_pkg::NUM_SYM; k++) begin
			// high side takes a 0, low side a 1
			if (rec.high_members[k]) begin
				next_codes[k].code = {base[k].code[W-2:0], 1'b0};
				next_codes[k].mask = {base[k].mask[W-2:0], 1'b1};
			end else if (rec.low_members[k]) begin
				next_codes[k].code = {base[k].code[W-2:0], 1'b1};
				next_codes[k].mask = {base[k].mask[W-2:0], 1'b1};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || busy)
			codes <= next_codes;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			idx  <= 3'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start || busy) begin
				idx  <= idx_now - 3'd1;
				busy <= (idx_now != 3'd0);
				done <= (idx_now == 3'd0);
			end
		end
	end

	// every symbol is a leaf below the root, so its mask is a gapless run of at least one
	for (genvar k = 0; k < huffman_pkg::NUM_SYM; k++) begin : g_mask_chk
		a_mask_run: assert property (@(posedge clk) disable iff (reset)
			done |-> codes[k].mask[0] && (codes[k].mask & (codes[k].mask + 1'b1)) == '0)
			else $error("mask of symbol %0d is not a run of ones", k + 1);
	end

endmodule

`default_nettype wire

// File: hw/merge_engine.sv
`default_nettype none

module merge_engine (
	input  wire                                                 clk,
	input  wire                                                 reset,
	input  wire                                                 start,
	input  wire  huffman_pkg::node_t [huffman_pkg::NUM_SYM-1:0] sorted,
	output huffman_pkg::merge_rec_t [huffman_pkg::NUM_MERGE-1:0] records,
	output logic                                                done
);

	logic       busy;
	logic       active;
	logic [2:0] step;
	logic [2:0] step_now;
	// working list, shrinks by one live entry per merge
	huffman_pkg::node_list_t work;
	huffman_pkg::node_list_t base;
	huffman_pkg::node_list_t rest;
	huffman_pkg::node_t      merged;

	assign active = start || busy;

	// ========================================
	// merge of the two front nodes
	// ========================================
	always_comb begin
		step_now       = start ? 3'd0 : step;
		base           = start ? sorted : work;
		merged.count   = base[0].count + base[1].count;
		merged.members = base[0].members | base[1].members;
		rest           = '0;
		for (int i = 0; i < huffman_pkg::NUM_SYM - 2; i++) begin
			rest[i] = base[i+2];
		end
	end

	always_ff @(posedge clk) begin
		if (active) begin
			work <= huffman_pkg::insert_node(rest, 3'(huffman_pkg::NUM_SYM - 2) - step_now,
				merged);
			records[step_now] <= '{low_members: base[0].members,
				high_members: base[1].members};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			step <= 3'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (active) begin
				step <= step_now + 3'd1;
				busy <= (step_now != 3'(huffman_pkg::NUM_MERGE - 1));
				done <= (step_now == 3'(huffman_pkg::NUM_MERGE - 1));
			end
		end
	end

	// the sorter and every earlier reinsert keep the list ascending
	a_merge_order: assert property (@(posedge clk) disable iff (reset)
		active |-> base[0].count <= base[1].count)
		else $error("merge with position 1 count above position 2 count");

endmodule

`default_nettype wire

// File: hw/leaf_sorter.sv
`default_nettype none

module leaf_sorter (
	input  wire                                            clk,
	input  wire                                            reset,
	input  wire                                            start,
	input  wire  huffman_pkg::count_t [huffman_pkg::NUM_SYM-1:0] counts,
	output huffman_pkg::node_t [huffman_pkg::NUM_SYM-1:0]  sorted,
	output logic                                           done
);

	logic       busy;
	logic [2:0] used;
	// leaves already in the list, also the index of the next symbol
	logic [2:0] used_now;
	huffman_pkg::node_t leaf;

	// ========================================
	// next leaf
	// ========================================
	always_comb begin
		used_now     = start ? 3'd0 : used;
		leaf.count   = counts[used_now];
		leaf.members = huffman_pkg::sym_mask_t'(1) << used_now;
	end

	// symbols arrive in rising order, so a tie puts the newer one lower
	always_ff @(posedge clk) begin
		if (start || busy)
			sorted <= huffman_pkg::insert_node(sorted, used_now, leaf);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			used <= 3'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start || busy) begin
				used <= used_now + 3'd1;
				busy <= (used_now != 3'(huffman_pkg::NUM_SYM - 1));
				done <= (used_now == 3'(huffman_pkg::NUM_SYM - 1));
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/symbol_counter.sv
`default_nettype none

module symbol_counter (
	input  wire                                          clk,
	input  wire                                          reset,
	input  wire                                          gray_valid,
	input  wire  [7:0]                                   gray_data,
	output huffman_pkg::count_t [huffman_pkg::NUM_SYM-1:0] counts
);

	// stream started, stream ended
	logic seen;
	logic closed;
	logic [huffman_pkg::NUM_SYM-1:0] hit;

	// one-hot select of the counter to bump, values outside 1..6 hit nothing
	always_comb begin
		for (int k = 0; k < huffman_pkg::NUM_SYM; k++) begin
			hit[k] = gray_valid && !closed && (gray_data == 8'(k + 1));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			seen   <= 1'b0;
			closed <= 1'b0;
			counts <= '0;
		end else begin
			if (gray_valid)
				seen <= 1'b1;
			// counts freeze once the stream has dropped
			if (seen && !gray_valid)
				closed <= 1'b1;
			for (int k = 0; k < huffman_pkg::NUM_SYM; k++) begin
				if (hit[k])
					counts[k] <= counts[k] + 1'b1;
			end
		end
	end

	a_one_counter: assert property (@(posedge clk) disable iff (reset)
		$countones({counts[0] != $past(counts[0]), counts[1] != $past(counts[1]),
			counts[2] != $past(counts[2]), counts[3] != $past(counts[3]),
			counts[4] != $past(counts[4]), counts[5] != $past(counts[5])}) <= 1)
		else $error("more than one symbol counter moved in one cycle");

endmodule

`default_nettype wire

// File: hw/huffman_pkg.sv
`default_nettype none

package huffman_pkg;

	// ========================================
	// sizes
	// ========================================
	localparam int NUM_SYM   = 6;
	localparam int NUM_MERGE = 5;
	localparam int COUNT_W   = 8;
	localparam int CODE_W    = 8;

	typedef logic [COUNT_W-1:0] count_t;

	// bit k-1 stands for symbol k
	typedef logic [NUM_SYM-1:0] sym_mask_t;

	typedef struct packed {
		count_t    count;
		sym_mask_t members;
	} node_t;

	typedef node_t [NUM_SYM-1:0] node_list_t;

	// low side is position 1 of the merge, high side position 2
	typedef struct packed {
		sym_mask_t low_members;
		sym_mask_t high_members;
	} merge_rec_t;

	typedef struct packed {
		logic [CODE_W-1:0] code;
		logic [CODE_W-1:0] mask;
	} code_t;

	typedef enum logic [2:0] {
		IDLE,
		RECEIVE,
		COUNT_OUT,
		SORT,
		MERGE,
		SPLIT,
		CODE_OUT,
		DONE
	} phase_e;

	// ========================================
	// ordered insert
	// ========================================
	// item goes ahead of every live entry with count >= its own
	function automatic node_list_t insert_node(node_list_t list, logic [2:0] used, node_t item);
		node_list_t result;
		logic [NUM_SYM-1:0] below;
		for (int i = 0; i < NUM_SYM; i++) begin
			below[i] = (i < int'(used)) && (list[i].count < item.count);
		end
		result[0] = below[0] ? list[0] : item;
		// entries past the insert point move up by one
		for (int i = 1; i < NUM_SYM; i++) begin
			if (below[i])
				result[i] = list[i];
			else if (below[i-1])
				result[i] = item;
			else
				result[i] = list[i-1];
		end
		return result;
	endfunction

endpackage

`default_nettype wire
